/* mem_access_unit.f */
verilog/mem_access_pkg.sv
verilog/store_formatter.sv
verilog/load_aligner.sv
verilog/dcache_dma.sv
verilog/mem_access_unit.sv
tb/mem_access_unit_asserts.sv
tb/mem_access_unit_tb.sv

/* Bender.yml */
package:
  name: mem_access_unit

sources:
  - files:
      - verilog/mem_access_pkg.sv
      - verilog/store_formatter.sv
      - verilog/load_aligner.sv
      - verilog/dcache_dma.sv
      - verilog/mem_access_unit.sv
  - target: test
    files:
      - tb/mem_access_unit_asserts.sv
      - tb/mem_access_unit_tb.sv

/* tb/mem_access_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit_tb;

    localparam int STORE_ITERS = 8;
    localparam int LOAD_REQS   = 40;
    localparam int MIS_REQS    = 8;
    localparam int BP_REQS     = 60;
    localparam int ZERO_REQS   = 6;
    // store and misaligned tests each add a word load
    localparam int TOTAL_REQS  = STORE_ITERS * 6 + LOAD_REQS + MIS_REQS * 2 + BP_REQS
                                 + ZERO_REQS * 2;
    // slowest load is 7 cycles
    localparam int TIMEOUT_CYCLES = 10 * TOTAL_REQS * 8;

    logic                  clk = 1'b0;
    logic                  rstn, req_valid, req_write, req_unsigned, req_ready;
    logic                  resp_valid, resp_misaligned, mem_req, mem_wr;
    logic                  mem_addr_ok, mem_data_ok;
    mem_access_pkg::size_t req_size, mem_size;
    mem_access_pkg::addr_t req_addr, mem_addr;
    mem_access_pkg::word_t req_wdata, resp_rdata, mem_wdata, mem_rdata;
    mem_access_pkg::strb_t mem_wstrb;

    mem_access_pkg::word_t mem [16];
    mem_access_pkg::word_t shadow [16];
    logic [3:0]            load_index;

    logic                  exp_mis, exp_write;
    mem_access_pkg::size_t exp_size;
    mem_access_pkg::strb_t exp_strb;
    mem_access_pkg::word_t exp_rdata, exp_lanes;

    logic [31:0]           rng_state = 32'h1ef9d227;
    int                    errors = 0, checks = 0, tests_run = 0, resp_count = 0;
    int                    cycle_count = 0, last_latency, err_mark;
    mem_access_pkg::addr_t addr_v;
    mem_access_pkg::size_t size_v;

    mem_access_unit dut (.*);

    always #20 clk = ~clk;

    //////////////////////////////
    // helpers and reference model
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = next_rand();
        return r[0];
    endfunction

    // 6-bit address inside the 16-word memory, aligned to the size
    function automatic mem_access_pkg::addr_t aligned_addr(input mem_access_pkg::size_t sz);
        mem_access_pkg::addr_t a;
        a = next_rand() & 32'h3f;
        if (sz == mem_access_pkg::SIZE_HALF) a[0] = 1'b0;
        if (sz == mem_access_pkg::SIZE_WORD) a[1:0] = 2'b00;
        return a;
    endfunction

    function automatic logic misaligned_ref(input mem_access_pkg::size_t sz,
                                            input mem_access_pkg::addr_t a);
        if (sz == mem_access_pkg::SIZE_HALF) return a[0];
        if (sz == mem_access_pkg::SIZE_WORD) return a[1:0] != 2'b00;
        return 1'b0;
    endfunction

    // one bit per byte covered by the access
    function automatic mem_access_pkg::strb_t strobe_ref(input mem_access_pkg::size_t sz,
                                                        input mem_access_pkg::addr_t a);
        mem_access_pkg::strb_t s;
        int                    nbytes;
        int                    first;
        nbytes = (sz == mem_access_pkg::SIZE_BYTE) ? 1 :
                 (sz == mem_access_pkg::SIZE_HALF) ? 2 : 4;
        first  = int'(a[1:0]) & ~(nbytes - 1);
        for (int i = 0; i < 4; i++) begin
            s[i] = (i >= first) && (i < first + nbytes);
        end
        return s;
    endfunction

    // store data moved into its lanes, zero in the others
    function automatic mem_access_pkg::word_t lanes_ref(input mem_access_pkg::size_t sz,
                                                       input mem_access_pkg::addr_t a,
                                                       input mem_access_pkg::word_t wd);
        case (sz)
            mem_access_pkg::SIZE_BYTE: return {24'b0, wd[7:0]} << (8 * a[1:0]);
            mem_access_pkg::SIZE_HALF: return {16'b0, wd[15:0]} << (16 * a[1]);
            default:                   return wd;
        endcase
    endfunction

    function automatic mem_access_pkg::word_t lane_mask(input mem_access_pkg::strb_t s);
        mem_access_pkg::word_t m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{s[i]}};
        end
        return m;
    endfunction

    // expected load value from the shadow memory
    function automatic mem_access_pkg::word_t load_ref(input mem_access_pkg::size_t sz,
                                                      input logic uns,
                                                      input mem_access_pkg::addr_t a);
        mem_access_pkg::word_t w;
        logic [7:0]            b;
        logic [15:0]           h;
        w = shadow[a[5:2]];
        b = w[8*a[1:0] +: 8];
        h = w[16*a[1] +: 16];
        case (sz)
            mem_access_pkg::SIZE_BYTE: return {{24{b[7] & ~uns}}, b};
            mem_access_pkg::SIZE_HALF: return {{16{h[15] & ~uns}}, h};
            default:                   return w;
        endcase
    endfunction

    task automatic shadow_store(input mem_access_pkg::size_t sz,
                                input mem_access_pkg::addr_t a,
                                input mem_access_pkg::word_t wd);
        case (sz)
            mem_access_pkg::SIZE_BYTE: shadow[a[5:2]][8*a[1:0] +: 8] = wd[7:0];
            mem_access_pkg::SIZE_HALF: shadow[a[5:2]][16*a[1] +: 16] = wd[15:0];
            default:                   shadow[a[5:2]] = wd;
        endcase
    endtask

    function automatic int error_total();
        return errors + dut.u_dcache_dma.u_asserts.fail_count;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED at %0t: %0s expected %0h got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0s: %0s", name, (error_total() == err_mark) ? "passed" : "failed");
        err_mark = error_total();
    endtask

    //////////////////////////////
    // driver and memory model
    //////////////////////////////

    // called on a falling edge, returns on the falling edge after the response
    task automatic do_access(input logic wr, input mem_access_pkg::size_t sz, input logic uns,
                             input mem_access_pkg::addr_t addr,
                             input mem_access_pkg::word_t wd, input int fixed_wait);
        int   addr_wait;
        int   data_wait;
        int   cyc;
        int   latency;
        int   resp_before;
        logic accepted;
        logic done;
        addr_wait = (fixed_wait >= 0) ? fixed_wait : int'(next_rand() % 4);
        data_wait = 1 + int'(next_rand() % 3);
        exp_mis   = misaligned_ref(sz, addr);
        exp_write = wr;
        exp_size  = sz;
        exp_rdata = load_ref(sz, uns, addr);
        exp_strb  = strobe_ref(sz, addr);
        exp_lanes = lanes_ref(sz, addr, wd);
        req_valid    = 1'b1;
        req_write    = wr;
        req_size     = sz;
        req_unsigned = uns;
        req_addr     = addr;
        req_wdata    = wd;
        accepted     = 1'b0;
        done         = 1'b0;
        cyc          = 0;
        latency      = 0;
        resp_before  = resp_count;
        while (!done) begin
            mem_addr_ok = ~exp_mis & ~accepted & (cyc >= addr_wait);
            mem_data_ok = accepted & ~wr & (cyc >= data_wait);
            mem_rdata   = mem_data_ok ? mem[load_index] : next_rand();
            @(posedge clk);
            latency++;
            done = req_ready;
            if (mem_addr_ok) begin
                accepted = 1'b1;
                cyc = 0;
            end
            @(negedge clk);
            cyc++;
        end
        if (wr && !exp_mis) shadow_store(sz, addr, wd);
        mem_addr_ok  = 1'b0;
        mem_data_ok  = 1'b0;
        req_valid    = 1'b0;
        last_latency = latency;
        compare_value("resp_valid count", resp_before + 1, resp_count);
    endtask

    always @(posedge clk) begin
        if (mem_req && mem_addr_ok && mem_wr) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_wstrb[i]) mem[mem_addr[5:2]][8*i +: 8] <= mem_wdata[8*i +: 8];
            end
        end else if (mem_req && mem_addr_ok) begin
            load_index <= mem_addr[5:2];
        end
    end

    //////////////////////////////
    // checker and timeout
    //////////////////////////////

    always @(posedge clk) begin
        if (rstn && resp_valid) begin
            resp_count++;
            assert (req_valid) else begin
                errors++;
                $display("response at %0t while no request was pending", $time);
            end
            compare_value("req_ready", 1, req_ready);
            compare_value("resp_misaligned", exp_mis, resp_misaligned);
            compare_value("mem_wr", exp_write, mem_wr);
            compare_value("mem_size", exp_size, mem_size);
            if (exp_mis) begin
                compare_value("mem_req", 0, mem_req);
            end else if (exp_write) begin
                compare_value("mem_addr_ok", 1, mem_addr_ok);
                compare_value("mem_wstrb", exp_strb, mem_wstrb);
                compare_value("mem_wdata", exp_lanes, mem_wdata & lane_mask(exp_strb));
            end else begin
                compare_value("mem_data_ok", 1, mem_data_ok);
                compare_value("resp_rdata", exp_rdata, resp_rdata);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        rstn = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_size = mem_access_pkg::SIZE_BYTE;
        req_unsigned = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata = '0;
        load_index = '0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = 32'h8f3a5c71 ^ (i * 32'h10210409);
            shadow[i] = mem[i];
        end
        err_mark = 0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;

        @(posedge clk);
        compare_value("mem_req", 0, mem_req);
        compare_value("resp_valid", 0, resp_valid);
        compare_value("req_ready", 1, req_ready);
        @(negedge clk);
        end_test("reset");

        for (int i = 0; i < STORE_ITERS; i++) begin
            for (int s = 0; s < 3; s++) begin
                size_v = mem_access_pkg::size_t'(s);
                addr_v = aligned_addr(size_v);
                do_access(1'b1, size_v, 1'b0, addr_v, next_rand(), -1);
                do_access(1'b0, mem_access_pkg::SIZE_WORD, 1'b0, addr_v & 32'h3c, '0, -1);
            end
        end
        end_test("store_format");

        for (int i = 0; i < LOAD_REQS; i++) begin
            size_v = rand_bit() ? mem_access_pkg::SIZE_HALF : mem_access_pkg::SIZE_BYTE;
            do_access(1'b0, size_v, rand_bit(), aligned_addr(size_v), '0, -1);
        end
        end_test("load_extract");

        for (int i = 0; i < MIS_REQS; i++) begin
            if (rand_bit()) begin
                size_v = mem_access_pkg::SIZE_HALF;
                addr_v = (next_rand() & 32'h3e) | 32'h1;
            end else begin
                size_v = mem_access_pkg::SIZE_WORD;
                addr_v = (next_rand() & 32'h3c) | (1 + next_rand() % 3);
            end
            do_access(rand_bit(), size_v, 1'b0, addr_v, next_rand(), -1);
            do_access(1'b0, mem_access_pkg::SIZE_WORD, 1'b0, addr_v & 32'h3c, '0, -1);
        end
        end_test("misaligned");

        for (int i = 0; i < BP_REQS; i++) begin
            size_v = mem_access_pkg::size_t'(next_rand() % 3);
            do_access(rand_bit(), size_v, rand_bit(), aligned_addr(size_v),
                      next_rand(), -1);
        end
        end_test("backpressure");

        for (int i = 0; i < ZERO_REQS; i++) begin
            addr_v = aligned_addr(mem_access_pkg::SIZE_WORD);
            do_access(1'b1, mem_access_pkg::SIZE_WORD, 1'b0, addr_v, next_rand(), 0);
            compare_value("store latency", 1, last_latency);
            do_access(1'b0, mem_access_pkg::SIZE_WORD, 1'b0, addr_v, '0, -1);
        end
        end_test("zero_delay");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, error_total());
        if (error_total() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/mem_access_unit_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit_asserts (
    input wire                             clk,
    input wire                             rstn,
    input wire                             req_valid,
    input wire                             resp_valid,
    input wire                             mem_req,
    input wire                             mem_addr_ok,
    input wire mem_access_pkg::dma_state_t state
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    // bus request is held until the address is taken
    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_addr_ok) |=> mem_req)
        else begin
            fail_count++;
            $error("mem_req dropped before mem_addr_ok");
        end

    a_resp_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |-> req_valid)
        else begin
            fail_count++;
            $error("resp_valid high without req_valid");
        end

    a_legal_state: assert property (@(posedge clk) disable iff (!rstn)
        state inside {mem_access_pkg::ST_IDLE, mem_access_pkg::ST_REQ,
                      mem_access_pkg::ST_WAIT_DATA})
        else begin
            fail_count++;
            $error("controller in an illegal state");
        end

endmodule

// one checker per controller instance
bind dcache_dma mem_access_unit_asserts u_asserts (
    .clk         (clk),
    .rstn        (rstn),
    .req_valid   (req_valid),
    .resp_valid  (resp_valid),
    .mem_req     (mem_req),
    .mem_addr_ok (mem_addr_ok),
    .state       (state)
);

`default_nettype wire

/* verilog/mem_access_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit (
    input  wire                        clk,
    input  wire                        rstn,

    // pipeline request
    input  wire                        req_valid,
    input  wire                        req_write,
    input  wire mem_access_pkg::size_t req_size,
    input  wire                        req_unsigned,
    input  wire mem_access_pkg::addr_t req_addr,
    input  wire mem_access_pkg::word_t req_wdata,
    output logic                       req_ready,

    // pipeline response
    output logic                       resp_valid,
    output mem_access_pkg::word_t      resp_rdata,
    output logic                       resp_misaligned,

    // memory bus
    output logic                       mem_req,
    output logic                       mem_wr,
    output mem_access_pkg::size_t      mem_size,
    output mem_access_pkg::addr_t      mem_addr,
    output mem_access_pkg::word_t      mem_wdata,
    output mem_access_pkg::strb_t      mem_wstrb,
    input  wire                        mem_addr_ok,
    input  wire                        mem_data_ok,
    input  wire mem_access_pkg::word_t mem_rdata
);

    logic misaligned;

    // request fields go straight to the bus
    assign mem_wr   = req_write;
    assign mem_size = req_size;
    assign mem_addr = req_addr;

    assign resp_misaligned = misaligned;

    //////////////////////////////
    // datapath
    //////////////////////////////

    store_formatter u_store_formatter (
        .req_size   (req_size),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .misaligned (misaligned),
        .mem_wstrb  (mem_wstrb),
        .mem_wdata  (mem_wdata)
    );

    // request fields are held stable until the response
    load_aligner u_load_aligner (
        .req_size     (req_size),
        .req_unsigned (req_unsigned),
        .req_addr     (req_addr),
        .mem_rdata    (mem_rdata),
        .resp_rdata   (resp_rdata)
    );

    //////////////////////////////
    // control
    //////////////////////////////

    dcache_dma u_dcache_dma (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .misaligned  (misaligned),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .mem_req     (mem_req),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok)
    );

endmodule

`default_nettype wire

/* verilog/dcache_dma.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_dma (
    input  wire  clk,
    input  wire  rstn,

    // pipeline handshake
    input  wire  req_valid,
    input  wire  req_write,
    input  wire  misaligned,
    output logic req_ready,
    output logic resp_valid,

    // memory handshake
    output logic mem_req,
    input  wire  mem_addr_ok,
    input  wire  mem_data_ok
);

    mem_access_pkg::dma_state_t state;
    mem_access_pkg::dma_state_t next_state;
    logic                       start;
    logic                       done;

    // aligned request seen in idle goes to the bus
    assign start = req_valid & ~misaligned;

    //////////////////////////////
    // state register
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= mem_access_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            mem_access_pkg::ST_IDLE: begin
                // addr_ok can already come in the cycle mem_req rises
                if (start) begin
                    if (!mem_addr_ok) begin
                        next_state = mem_access_pkg::ST_REQ;
                    end else if (req_write) begin
                        next_state = mem_access_pkg::ST_IDLE;
                    end else begin
                        next_state = mem_access_pkg::ST_WAIT_DATA;
                    end
                end
            end
            mem_access_pkg::ST_REQ: begin
                if (mem_addr_ok) begin
                    // store ends at address accept
                    if (req_write) begin
                        next_state = mem_access_pkg::ST_IDLE;
                    end else begin
                        next_state = mem_access_pkg::ST_WAIT_DATA;
                    end
                end
            end
            mem_access_pkg::ST_WAIT_DATA: begin
                if (mem_data_ok) begin
                    next_state = mem_access_pkg::ST_IDLE;
                end
            end
            default: begin
                next_state = mem_access_pkg::ST_IDLE;
            end
        endcase
    end

    // access finishes when the FSM lands back in idle
    assign done = (next_state == mem_access_pkg::ST_IDLE);

    //////////////////////////////
    // outputs
    //////////////////////////////

    always_comb begin
        mem_req    = 1'b0;
        req_ready  = 1'b0;
        resp_valid = 1'b0;
        case (state)
            mem_access_pkg::ST_IDLE: begin
                mem_req   = start;
                // also high with no request pending
                req_ready = done;
                // covers misaligned and zero-wait stores
                resp_valid = req_valid & done;
            end
            mem_access_pkg::ST_REQ: begin
                mem_req    = 1'b1;
                req_ready  = done;
                resp_valid = done;
            end
            mem_access_pkg::ST_WAIT_DATA: begin
                req_ready  = done;
                resp_valid = done;
            end
            default: begin
                mem_req = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/load_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module load_aligner (
    input  wire mem_access_pkg::size_t req_size,
    input  wire                        req_unsigned,
    input  wire mem_access_pkg::addr_t req_addr,
    input  wire mem_access_pkg::word_t mem_rdata,
    output mem_access_pkg::word_t      resp_rdata
);

    logic [1:0]             lane;
    mem_access_pkg::word_t  shifted;
    logic [7:0]             byte_val;
    logic [15:0]            half_val;
    logic                   byte_sign;
    logic                   half_sign;

    assign lane = req_addr[1:0];

    //////////////////////////////
    // lane extraction
    //////////////////////////////

    // move the addressed lane down to bit 0
    always_comb begin
        case (req_size)
            mem_access_pkg::SIZE_BYTE: begin
                shifted = mem_rdata >> {lane, 3'b000};
            end
            mem_access_pkg::SIZE_HALF: begin
                shifted = mem_rdata >> {lane[1], 4'b0000};
            end
            default: begin
                shifted = mem_rdata;
            end
        endcase
    end

    assign byte_val = shifted[7:0];
    assign half_val = shifted[15:0];

    // no sign fill for unsigned loads
    assign byte_sign = byte_val[7] & ~req_unsigned;
    assign half_sign = half_val[15] & ~req_unsigned;

    //////////////////////////////
    // extension
    //////////////////////////////

    always_comb begin
        case (req_size)
            mem_access_pkg::SIZE_BYTE: begin
                resp_rdata = {{24{byte_sign}}, byte_val};
            end
            mem_access_pkg::SIZE_HALF: begin
                resp_rdata = {{16{half_sign}}, half_val};
            end
            default: begin
                // word loads come back untouched
                resp_rdata = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/store_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

module store_formatter (
    input  wire mem_access_pkg::size_t req_size,
    input  wire mem_access_pkg::addr_t req_addr,
    input  wire mem_access_pkg::word_t req_wdata,
    output logic                       misaligned,
    output mem_access_pkg::strb_t      mem_wstrb,
    output mem_access_pkg::word_t      mem_wdata
);

    logic [1:0] lane;

    assign lane = req_addr[1:0];

    //////////////////////////////
    // alignment check
    //////////////////////////////

    always_comb begin
        case (req_size)
            mem_access_pkg::SIZE_BYTE: begin
                misaligned = 1'b0;
            end
            mem_access_pkg::SIZE_HALF: begin
                misaligned = lane[0];
            end
            // word, and the unused code is handled like a word
            default: begin
                misaligned = (lane != 2'b00);
            end
        endcase
    end

    //////////////////////////////
    // strobe and lane placement
    //////////////////////////////

    // data is replicated, so the strobe alone picks the lanes
    always_comb begin
        case (req_size)
            mem_access_pkg::SIZE_BYTE: begin
                mem_wstrb = mem_access_pkg::strb_t'(4'b0001 << lane);
                mem_wdata = {4{req_wdata[7:0]}};
            end
            mem_access_pkg::SIZE_HALF: begin
                // upper or lower half by address bit 1
                mem_wstrb = lane[1] ? 4'b1100 : 4'b0011;
                mem_wdata = {2{req_wdata[15:0]}};
            end
            default: begin
                mem_wstrb = 4'b1111;
                mem_wdata = req_wdata;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mem_access_pkg.sv */
`default_nettype none

package mem_access_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // one strobe bit per byte lane
    localparam int STRB_W = DATA_W / 8;
    localparam int SIZE_W = 2;

    // byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // full data word, as the bus moves it
    typedef logic [DATA_W-1:0] word_t;

    typedef logic [STRB_W-1:0] strb_t;

    typedef logic [SIZE_W-1:0] size_t;

    //////////////////////////////
    // access size encoding
    //////////////////////////////

    // same values as the bus size field
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    //////////////////////////////
    // controller FSM
    //////////////////////////////

    // idle, address phase, waiting for load data
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_REQ       = 2'd1,
        ST_WAIT_DATA = 2'd2
    } dma_state_t;

endpackage

`default_nettype wire
